/* bench/mmio_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_assert import afu_pkg::*; (
  input logic       clock,
  input logic       rstn,
  input logic       mmio_valid,
  input logic       mmio_ack,
  input err_flags_t mmio_errors
);

  int fail_count = 0;

  // Registered outputs show up one sample after their edge
  ack_after_request: assert property (@(posedge clock) disable iff (!rstn)
    mmio_valid |-> ##(ack_latency + 1) mmio_ack)
    else begin
      $error("no acknowledge at the fixed latency after a request");
      fail_count++;
    end

  ack_has_request: assert property (@(posedge clock) disable iff (!rstn)
    mmio_ack |-> $past(mmio_valid, ack_latency + 1))
    else begin
      $error("acknowledge without a matching request");
      fail_count++;
    end

  errors_quiet: assert property (@(posedge clock) disable iff (!rstn)
    !$past(mmio_valid, err_latency + 1) |-> (mmio_errors == '0))
    else begin
      $error("error lines active with no request behind them");
      fail_count++;
    end

endmodule

bind mmio_frontend mmio_assert u_assert (
  .clock       (clock),
  .rstn        (rstn),
  .mmio_valid  (mmio_valid),
  .mmio_ack    (mmio_ack),
  .mmio_errors (mmio_errors)
);

`default_nettype wire

/* bench/mmio_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_checker import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  logic       mmio_valid,
  input  logic       mmio_cfg,
  input  logic       mmio_read,
  input  logic       mmio_dw,
  input  mmio_addr_t mmio_addr,
  input  logic       mmio_addr_par,
  input  mmio_data_t mmio_wdata,
  input  logic       mmio_wdata_par,
  input  mmio_data_t report_errors,
  input  logic       mmio_ack,
  input  mmio_data_t mmio_rdata,
  input  logic       mmio_rdata_par,
  input  err_flags_t mmio_errors,
  input  logic       report_errors_ack,
  output int         error_count,
  output int         pending
);

  // Reference state of the two counters
  mmio_data_t cnt_1;
  mmio_data_t cnt_2;
  int         tick;

  // Expected responses, oldest first
  int         ack_due [$];
  mmio_data_t ack_data [$];
  logic       ack_rep [$];
  int         err_due [$];
  err_flags_t err_flags [$];

  function automatic logic odd_fill_bit(input mmio_data_t value);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) begin
      ones += int'(value[i]);
    end
    return (ones % 2) == 0;
  endfunction

  function automatic mmio_data_t desc_model(input mmio_addr_t addr);
    int idx;
    idx = int'(addr[5:1]);
    if (idx < desc_count) begin
      return desc_words[idx];
    end
    return '0;
  endfunction

  task automatic flag_mismatch(input string what, input mmio_data_t got, input mmio_data_t exp);
    $display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    error_count++;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic model_request();
    logic       addr_bad;
    logic       data_bad;
    logic       rep;
    mmio_data_t word;
    addr_bad = odd_fill_bit(mmio_data_t'(mmio_addr)) != mmio_addr_par;
    data_bad = !mmio_read && (odd_fill_bit(mmio_wdata) != mmio_wdata_par);
    word     = '0;
    rep      = 1'b0;
    if (!mmio_read && !mmio_cfg && !addr_bad && !data_bad) begin
      if (mmio_addr == reg_counter_1) begin
        cnt_1 = mmio_wdata;
      end else if (mmio_addr == reg_counter_2) begin
        cnt_2 = mmio_wdata;
      end
    end else if (mmio_read && !addr_bad) begin
      if (mmio_cfg) begin
        word = desc_model(mmio_addr);
      end else if (mmio_addr == reg_counter_1) begin
        word  = cnt_1;
        cnt_1 = cnt_1 + counter_1_step;
      end else if (mmio_addr == reg_counter_2) begin
        word  = cnt_2;
        cnt_2 = cnt_2 + counter_2_step;
      end else if (mmio_addr == reg_error_report) begin
        word = report_errors;
        rep  = 1'b1;
      end
    end
    // Even word is the upper half
    if (!mmio_dw) begin
      word = mmio_addr[0] ? {2{word[31:0]}} : {2{word[63:32]}};
    end
    // Outputs are seen at the falling edge after the driving edge
    ack_due.push_back(tick + ack_latency + 1);
    ack_data.push_back(word);
    ack_rep.push_back(rep);
    err_due.push_back(tick + err_latency + 1);
    err_flags.push_back({data_bad, addr_bad});
  endtask

  //////////////////////////////
  // Comparison
  //////////////////////////////
  task automatic check_response();
    logic due;
    due = (ack_due.size() > 0) && (ack_due[0] == tick);
    if (due && !mmio_ack) begin
      $display("Acknowledge missing at time %0t for a request sent %0d cycles earlier",
               $time, ack_latency);
      error_count++;
    end else if (due) begin
      if (mmio_rdata !== ack_data[0]) flag_mismatch("mmio_rdata", mmio_rdata, ack_data[0]);
      if (mmio_rdata_par !== odd_fill_bit(ack_data[0])) begin
        flag_mismatch("mmio_rdata_par", mmio_rdata_par, odd_fill_bit(ack_data[0]));
      end
    end else if (mmio_ack !== 1'b0) begin
      $display("Extra acknowledge at time %0t with no request due", $time);
      error_count++;
    end
    if (report_errors_ack !== (due && ack_rep[0])) begin
      flag_mismatch("report_errors_ack", report_errors_ack, due && ack_rep[0]);
    end
    if (due) begin
      void'(ack_due.pop_front());
      void'(ack_data.pop_front());
      void'(ack_rep.pop_front());
    end
    if ((err_due.size() > 0) && (err_due[0] == tick)) begin
      if (mmio_errors !== err_flags[0]) flag_mismatch("mmio_errors", mmio_errors, err_flags[0]);
      void'(err_due.pop_front());
      void'(err_flags.pop_front());
    end else if (mmio_errors !== '0) begin
      flag_mismatch("mmio_errors idle", mmio_errors, '0);
    end
  endtask

  initial begin
    error_count = 0;
    pending     = 0;
  end

  // Falling edge sampling, inputs and outputs are both settled here
  always @(negedge clock) begin
    if (!rstn) begin
      tick  = 0;
      cnt_1 = '0;
      cnt_2 = '0;
    end else begin
      tick++;
      check_response();
      if (mmio_valid) begin
        model_request();
      end
    end
    pending = ack_due.size();
  end

endmodule

`default_nettype wire

/* bench/tb_afu_mmio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_afu_mmio import afu_pkg::*; ();

  typedef enum logic [1:0] {cfg_rd, cfg_wr, reg_rd, reg_wr} req_kind_t;

  // kind, address, data, doubleword, bad address parity, bad data parity, gap after
  typedef struct packed {
    req_kind_t  kind;
    mmio_addr_t addr;
    mmio_data_t data;
    logic       dw;
    logic       bad_addr;
    logic       bad_data;
    logic       gap;
  } req_row_t;

  localparam int num_rows = 27;
  localparam int timeout_cycles = num_rows * 4 + 50;

  localparam req_row_t rows [num_rows] = '{
    '{cfg_rd, 24'h00_0000, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0002, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0004, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0006, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0008, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0020, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{cfg_rd, 24'h00_0000, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0001, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0008, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{cfg_rd, 24'h00_0007, 64'h0, 1'b0, 1'b0, 1'b0, 1'b1},
    '{reg_wr, reg_counter_1, 64'h0000_0010_0000_00f0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_wr, reg_counter_2, 64'h0000_0000_0000_0100, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_1, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_1, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_1, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_2, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_2, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{reg_rd, reg_error_report, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_error_report, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{reg_rd, 24'h00_0005, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{reg_rd, reg_counter_1, 64'h0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{reg_wr, reg_counter_2, 64'h0000_0000_0000_dead, 1'b1, 1'b0, 1'b1, 1'b0},
    '{reg_rd, reg_counter_2, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{cfg_wr, 24'h00_0002, 64'h1234_5678_9abc_def0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_wr, 24'h00_0010, 64'h5555_aaaa_5555_aaaa, 1'b1, 1'b0, 1'b0, 1'b0},
    '{reg_wr, reg_counter_1, 64'h0000_0000_0bad_0bad, 1'b1, 1'b1, 1'b0, 1'b0},
    '{reg_rd, reg_counter_1, 64'h0, 1'b1, 1'b0, 1'b0, 1'b0}
  };

  logic       clock;
  logic       rstn;
  logic       mmio_valid;
  logic       mmio_cfg;
  logic       mmio_read;
  logic       mmio_dw;
  mmio_addr_t mmio_addr;
  logic       mmio_addr_par;
  mmio_data_t mmio_wdata;
  logic       mmio_wdata_par;
  mmio_data_t report_errors;
  logic       mmio_ack;
  mmio_data_t mmio_rdata;
  logic       mmio_rdata_par;
  err_flags_t mmio_errors;
  logic       report_errors_ack;
  int         error_count;
  int         pending;
  int         cycles;
  int         total_errors;

  afu_mmio_top u_dut (.*);
  mmio_checker u_checker (.*);

  always #4 clock = ~clock;

  task automatic drive_row(input req_row_t row);
    mmio_valid     = 1'b1;
    mmio_cfg       = (row.kind == cfg_rd) || (row.kind == cfg_wr);
    mmio_read      = (row.kind == cfg_rd) || (row.kind == reg_rd);
    mmio_dw        = row.dw;
    mmio_addr      = row.addr;
    mmio_addr_par  = odd_parity(mmio_data_t'(row.addr)) ^ row.bad_addr;
    mmio_wdata     = row.data;
    mmio_wdata_par = odd_parity(row.data) ^ row.bad_data;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clock);
      #1;
      mmio_valid = 1'b0;
    end
  endtask

  //////////////////////////////
  // Timeout
  //////////////////////////////
  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Run timed out after %0d cycles, %0d responses still outstanding",
               cycles, pending);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h2a01_46ce));
    clock          = 1'b0;
    rstn           = 1'b0;
    cycles         = 0;
    mmio_valid     = 1'b0;
    mmio_cfg       = 1'b0;
    mmio_read      = 1'b0;
    mmio_dw        = 1'b0;
    mmio_addr      = '0;
    mmio_addr_par  = 1'b1;
    mmio_wdata     = '0;
    mmio_wdata_par = 1'b1;
    report_errors  = 64'h0123_4567_89ab_cdef;
    repeat (3) @(posedge clock);
    #1;
    rstn = 1'b1;

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clock);
      #1;
      drive_row(rows[i]);
      if (rows[i].gap) begin
        idle_cycles(int'($urandom % 3) + 1);
      end
    end
    idle_cycles(1);

    // Drain, then a few quiet cycles to catch stray acks
    wait (pending == 0);
    idle_cycles(4);

    total_errors = error_count + u_dut.u_frontend.u_assert.fail_count;
    $display("Run finished: %0d checker errors, %0d assertion failures",
             error_count, u_dut.u_frontend.u_assert.fail_count);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/afu_descriptor.sv */
`timescale 1ns/1ps
`default_nettype none

module afu_descriptor import afu_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  logic        desc_rd,
  input  desc_index_t desc_idx,
  output mmio_data_t  desc_data
);

  mmio_data_t rom_word;

  // Table lookup, unused doublewords read as zero
  function automatic mmio_data_t desc_lookup(input desc_index_t idx);
    mmio_data_t word;
    word = '0;
    for (int i = 0; i < desc_count; i++) begin
      if (int'(idx) == i) begin
        word = desc_words[i];
      end
    end
    return word;
  endfunction

  assign rom_word = desc_lookup(desc_idx);

  //////////////////////////////
  // Registered read port
  //////////////////////////////

  // Output returns to zero between reads
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      desc_data <= '0;
    end else if (desc_rd) begin
      desc_data <= rom_word;
    end else begin
      desc_data <= '0;
    end
  end

endmodule

`default_nettype wire

/* logic/afu_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module afu_mmio_top import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  logic       mmio_valid,
  input  logic       mmio_cfg,
  input  logic       mmio_read,
  input  logic       mmio_dw,
  input  mmio_addr_t mmio_addr,
  input  logic       mmio_addr_par,
  input  mmio_data_t mmio_wdata,
  input  logic       mmio_wdata_par,
  input  mmio_data_t report_errors,
  output logic       mmio_ack,
  output mmio_data_t mmio_rdata,
  output logic       mmio_rdata_par,
  output err_flags_t mmio_errors,
  output logic       report_errors_ack
);

  // Descriptor port
  logic        desc_rd;
  desc_index_t desc_idx;
  mmio_data_t  desc_data;

  // Register block port
  reg_access_if regs_if ();

  mmio_frontend u_frontend (
    .clock          (clock),
    .rstn           (rstn),
    .mmio_valid     (mmio_valid),
    .mmio_cfg       (mmio_cfg),
    .mmio_read      (mmio_read),
    .mmio_dw        (mmio_dw),
    .mmio_addr      (mmio_addr),
    .mmio_addr_par  (mmio_addr_par),
    .mmio_wdata     (mmio_wdata),
    .mmio_wdata_par (mmio_wdata_par),
    .desc_data      (desc_data),
    .desc_rd        (desc_rd),
    .desc_idx       (desc_idx),
    .mmio_ack       (mmio_ack),
    .mmio_rdata     (mmio_rdata),
    .mmio_rdata_par (mmio_rdata_par),
    .mmio_errors    (mmio_errors),
    .regs           (regs_if.initiator)
  );

  afu_descriptor u_descriptor (
    .clock     (clock),
    .rstn      (rstn),
    .desc_rd   (desc_rd),
    .desc_idx  (desc_idx),
    .desc_data (desc_data)
  );

  mmio_registers u_registers (
    .clock             (clock),
    .rstn              (rstn),
    .report_errors     (report_errors),
    .report_errors_ack (report_errors_ack),
    .regs              (regs_if.target)
  );

endmodule

`default_nettype wire

/* logic/afu_pkg.sv */
`default_nettype none

package afu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Word address on the host link, one word is 32 bits
  typedef logic [23:0] mmio_addr_t;
  typedef logic [63:0] mmio_data_t;
  // Doubleword index into the descriptor
  typedef logic [4:0]  desc_index_t;
  typedef logic [1:0]  reg_index_t;
  // Bit 1 data parity, bit 0 address parity
  typedef logic [1:0]  err_flags_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Word addresses of the registers
  localparam mmio_addr_t reg_counter_1    = 24'h00_0000;
  localparam mmio_addr_t reg_counter_2    = 24'h00_0002;
  localparam mmio_addr_t reg_error_report = 24'h00_0004;

  // Register select carried to the register block
  localparam reg_index_t reg_idx_counter_1    = 2'd0;
  localparam reg_index_t reg_idx_counter_2    = 2'd1;
  localparam reg_index_t reg_idx_error_report = 2'd2;
  localparam reg_index_t reg_idx_none         = 2'd3;

  // Added to a counter on each read
  localparam mmio_data_t counter_1_step = 64'd1;
  localparam mmio_data_t counter_2_step = 64'd3;

  //////////////////////////////
  // AFU descriptor
  //////////////////////////////

  localparam int desc_count = 5;

  // Doublewords past the table read as zero
  localparam mmio_data_t desc_words [desc_count] = '{
    64'h0000_0001_0001_8010, // ints per process, processes, config records, prog model
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_0100,
    64'h8000_0000_0000_0000
  };

  //////////////////////////////
  // Timing and parity
  //////////////////////////////

  // Cycles from a sampled request to its ack and its error flags
  localparam int ack_latency = 4;
  localparam int err_latency = 2;

  // Bit that makes the total count of ones odd
  function automatic logic odd_parity(input mmio_data_t value);
    return ~(^value);
  endfunction

endpackage

`default_nettype wire

/* logic/mmio_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_frontend import afu_pkg::*; (
  input  logic            clock,
  input  logic            rstn,
  input  logic            mmio_valid,
  input  logic            mmio_cfg,
  input  logic            mmio_read,
  input  logic            mmio_dw,
  input  mmio_addr_t      mmio_addr,
  input  logic            mmio_addr_par,
  input  mmio_data_t      mmio_wdata,
  input  logic            mmio_wdata_par,
  input  mmio_data_t      desc_data,
  output logic            desc_rd,
  output desc_index_t     desc_idx,
  output logic            mmio_ack,
  output mmio_data_t      mmio_rdata,
  output logic            mmio_rdata_par,
  output err_flags_t      mmio_errors,
  reg_access_if.initiator regs
);

  // Captured request
  logic       s0_valid;
  logic       s0_cfg;
  logic       s0_read;
  logic       s0_dw;
  mmio_addr_t s0_addr;
  logic       s0_addr_par;
  mmio_data_t s0_wdata;
  logic       s0_wdata_par;

  logic       addr_err;
  logic       data_err;
  logic       rd_ok;
  logic       wr_ok;

  // Pipeline side band
  logic       s1_valid;
  logic       s1_half;
  logic       s1_dw;
  err_flags_t s1_err;
  logic       s2_valid;
  logic       s2_sel_desc;
  logic       s2_sel_reg;
  logic       s2_half;
  logic       s2_dw;

  mmio_data_t src_word;
  mmio_data_t half_word;
  logic       s3_valid;
  mmio_data_t s3_data;
  logic       s3_par;

  function automatic reg_index_t reg_decode(input mmio_addr_t addr);
    case (addr)
      reg_counter_1:    return reg_idx_counter_1;
      reg_counter_2:    return reg_idx_counter_2;
      reg_error_report: return reg_idx_error_report;
      default:          return reg_idx_none;
    endcase
  endfunction

  //////////////////////////////
  // Edge 0: capture
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s0_valid <= 1'b0;
    end else begin
      s0_valid <= mmio_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_valid) begin
      s0_cfg       <= mmio_cfg;
      s0_read      <= mmio_read;
      s0_dw        <= mmio_dw;
      s0_addr      <= mmio_addr;
      s0_addr_par  <= mmio_addr_par;
      s0_wdata     <= mmio_wdata;
      s0_wdata_par <= mmio_wdata_par;
    end
  end

  // Data parity only matters for writes
  assign addr_err = s0_valid && (odd_parity(mmio_data_t'(s0_addr)) != s0_addr_par);
  assign data_err = s0_valid && !s0_read && (odd_parity(s0_wdata) != s0_wdata_par);
  assign rd_ok    = s0_valid && s0_read && !addr_err;
  assign wr_ok    = s0_valid && !s0_read && !addr_err && !data_err;

  //////////////////////////////
  // Edge 1: check and strobe
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_valid    <= 1'b0;
      s1_err      <= '0;
      desc_rd     <= 1'b0;
      regs.rd_stb <= 1'b0;
      regs.wr_stb <= 1'b0;
    end else begin
      s1_valid    <= s0_valid;
      s1_err      <= {data_err, addr_err};
      desc_rd     <= rd_ok && s0_cfg;
      regs.rd_stb <= rd_ok && !s0_cfg;
      // Config writes are acked but go nowhere
      regs.wr_stb <= wr_ok && !s0_cfg;
    end
  end

  always_ff @(posedge clock) begin
    s1_half    <= s0_addr[0];
    s1_dw      <= s0_dw;
    desc_idx   <= s0_addr[5:1];
    regs.index <= reg_decode(s0_addr);
    regs.wdata <= s0_wdata;
  end

  //////////////////////////////
  // Edge 2: error flags
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_errors <= '0;
      s2_valid    <= 1'b0;
      s2_sel_desc <= 1'b0;
      s2_sel_reg  <= 1'b0;
    end else begin
      mmio_errors <= s1_err;
      s2_valid    <= s1_valid;
      s2_sel_desc <= desc_rd;
      s2_sel_reg  <= regs.rd_stb;
    end
  end

  always_ff @(posedge clock) begin
    s2_half <= s1_half;
    s2_dw   <= s1_dw;
  end

  //////////////////////////////
  // Edge 3: half select, parity
  //////////////////////////////

  // Nothing selected means zero data, as for writes and bad addresses
  assign src_word = s2_sel_desc ? desc_data :
                    s2_sel_reg  ? regs.rdata : '0;

  // Even word sits in the upper half of the doubleword
  always_comb begin
    if (s2_dw) begin
      half_word = src_word;
    end else if (s2_half) begin
      half_word = {src_word[31:0], src_word[31:0]};
    end else begin
      half_word = {src_word[63:32], src_word[63:32]};
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clock) begin
    s3_data <= half_word;
    s3_par  <= odd_parity(half_word);
  end

  //////////////////////////////
  // Edge 4: response to host
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_ack       <= 1'b0;
      mmio_rdata     <= '0;
      mmio_rdata_par <= 1'b1;
    end else begin
      mmio_ack       <= s3_valid;
      mmio_rdata     <= s3_data;
      mmio_rdata_par <= s3_par;
    end
  end

endmodule

`default_nettype wire

/* logic/mmio_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_registers import afu_pkg::*; (
  input  logic         clock,
  input  logic         rstn,
  input  mmio_data_t   report_errors,
  output logic         report_errors_ack,
  reg_access_if.target regs
);

  localparam int num_counters = 2;

  // Per counter select and increment
  localparam reg_index_t cnt_idx [num_counters] = '{
    reg_idx_counter_1,
    reg_idx_counter_2
  };
  localparam mmio_data_t cnt_step [num_counters] = '{
    counter_1_step,
    counter_2_step
  };

  mmio_data_t counter [num_counters];
  mmio_data_t read_word;
  logic       err_ack_pend;
  logic       err_ack_dly;

  //////////////////////////////
  // Counting registers
  //////////////////////////////

  // A write loads, a read returns the old value and steps
  for (genvar i = 0; i < num_counters; i++) begin : g_counter
    always_ff @(posedge clock or negedge rstn) begin
      if (!rstn) begin
        counter[i] <= '0;
      end else if (regs.wr_stb && (regs.index == cnt_idx[i])) begin
        counter[i] <= regs.wdata;
      end else if (regs.rd_stb && (regs.index == cnt_idx[i])) begin
        counter[i] <= counter[i] + cnt_step[i];
      end
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////
  always_comb begin
    case (regs.index)
      reg_idx_counter_1:    read_word = counter[0];
      reg_idx_counter_2:    read_word = counter[1];
      reg_idx_error_report: read_word = report_errors;
      default:              read_word = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      regs.rdata <= '0;
    end else if (regs.rd_stb) begin
      regs.rdata <= read_word;
    end else begin
      regs.rdata <= '0;
    end
  end

  //////////////////////////////
  // Error report acknowledge
  //////////////////////////////

  // Two extra stages so the pulse meets mmio_ack
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_ack_pend      <= 1'b0;
      err_ack_dly       <= 1'b0;
      report_errors_ack <= 1'b0;
    end else begin
      err_ack_pend      <= regs.rd_stb && (regs.index == reg_idx_error_report);
      err_ack_dly       <= err_ack_pend;
      report_errors_ack <= err_ack_dly;
    end
  end

endmodule

`default_nettype wire

/* logic/reg_access_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if import afu_pkg::*; ();

  // Single-cycle commands, no handshake
  logic       rd_stb;
  logic       wr_stb;
  reg_index_t index;
  mmio_data_t wdata;

  // Valid the cycle after rd_stb
  mmio_data_t rdata;

  modport initiator (
    output rd_stb,
    output wr_stb,
    output index,
    output wdata,
    input  rdata
  );

  modport target (
    input  rd_stb,
    input  wr_stb,
    input  index,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* src.f */
logic/afu_pkg.sv
logic/reg_access_if.sv
logic/mmio_frontend.sv
logic/afu_descriptor.sv
logic/mmio_registers.sv
logic/afu_mmio_top.sv
bench/mmio_checker.sv
bench/mmio_assert.sv
bench/tb_afu_mmio.sv
